//--- list.f
verilog/lsu_pkg.sv
verilog/byte_bank.sv
verilog/store_align.sv
verilog/load_align.sv
verilog/data_mem_unit.sv
verilog/clear_counter.sv
verilog/lsu_ctrl.sv
verilog/lsu_top.sv
tb/lsu_tb.sv

//--- tb/lsu_tb.sv
/*
 Testbench for lsu_top with vectors from tb/lsu_tests.txt.
 Each line is op, address, store data, expected rdata and a wait-for-ready flag.
 A flag of 0 strobes at once and expects the strobe to be dropped.
 Op CLR pulses clear_start. Every ready-low stretch must last ROWS cycles.
*/
`timescale 1ns/1ps

module lsu_tb;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       req_strobe;
    lsu_pkg::mem_req_t          req;
    logic                       clear_start;
    logic                       ready;
    logic                       done;
    logic [lsu_pkg::XLEN-1:0]   rdata;

    // Vector storage
    string       v_op[$];
    logic [63:0] v_addr[$];
    logic [63:0] v_wdata[$];
    logic [63:0] v_exp[$];
    int          v_wait[$];
    logic        loaded = 1'b0;

    // Access strobed in the previous cycle and checked at the next falling edge
    logic        pend_accept = 1'b0;
    logic        pend_load = 1'b0;
    logic [63:0] pend_exp;
    int          pend_idx;
    int          low_run = 0;

    lsu_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .req_strobe  (req_strobe),
        .req         (req),
        .clear_start (clear_start),
        .ready       (ready),
        .done        (done),
        .rdata       (rdata)
    );

    // 20 ns period
    always #10 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED %s: got %h expected %h", name, got, exp));
        end
    endtask

    // Map an opcode name from the vector file onto the enum
    task automatic find_op(input string name, output lsu_pkg::mem_op_e op);
        lsu_pkg::mem_op_e cand;
        int               hit;
        hit = 0;
        cand = cand.first();
        op = cand;
        for (int k = 0; k < cand.num(); k++) begin
            if (cand.name() == name) begin
                op = cand;
                hit = 1;
            end
            cand = cand.next();
        end
        if (hit == 0) begin
            abort_run($sformatf("Unknown opcode %s in the vector file", name));
        end
    endtask

    // Step one cycle and check done and rdata for the access strobed last cycle
    task automatic advance_cycle();
        @(negedge clk);
        if (pend_accept) begin
            if (!done) begin
                abort_run($sformatf("No done one cycle after vector %0d was strobed", pend_idx));
            end else if (pend_load) begin
                check_value($sformatf("rdata (vector %0d)", pend_idx), rdata, pend_exp);
            end
        end else if (done) begin
            abort_run("done pulsed without an accepted strobe in the cycle before");
        end
        pend_accept = 1'b0;
        pend_load   = 1'b0;
        req_strobe  = 1'b0;
        clear_start = 1'b0;
    endtask

    // Sweep length as sampled before each rising edge updates the FSM
    always @(posedge clk) begin
        if (rst) begin
            low_run = 0;
        end else if (!ready) begin
            low_run = low_run + 1;
        end else if (low_run != 0) begin
            check_value("ready low cycles", low_run, lsu_pkg::ROWS);
            low_run = 0;
        end
    end

    initial begin
        longint limit;
        wait (loaded);
        limit = (3 * lsu_pkg::ROWS + 4 * v_op.size()) * 20;
        #(limit);
        abort_run("Timeout, the tests did not finish in the expected time");
    end

    initial begin
        int               fd;
        string            tok;
        logic [8*256-1:0] rest;
        logic [63:0]      a;
        logic [63:0]      w;
        logic [63:0]      e;
        int               f;
        lsu_pkg::mem_op_e op;
        rst = 1'b1;
        req_strobe = 1'b0;
        clear_start = 1'b0;
        req = '0;
        fd = $fopen("tb/lsu_tests.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open tb/lsu_tests.txt");
        end
        while (!$feof(fd)) begin
            if ($fscanf(fd, "%s", tok) != 1) begin
                break;
            end
            // Comment lines are skipped up to the end of the line
            if (tok[0] == "#") begin
                void'($fgets(rest, fd));
                continue;
            end
            if ($fscanf(fd, "%h %h %h %d", a, w, e, f) != 4) begin
                abort_run($sformatf("Malformed vector line starting with %s", tok));
            end
            v_op.push_back(tok);
            v_addr.push_back(a);
            v_wdata.push_back(w);
            v_exp.push_back(e);
            v_wait.push_back(f);
        end
        $fclose(fd);
        loaded = 1'b1;

        // Three rising edges in reset
        repeat (3) @(negedge clk);
        check_value("done", done, 0);
        check_value("ready", ready, 0);
        rst = 1'b0;

        foreach (v_op[i]) begin
            if (v_wait[i] != 0) begin
                while (!ready) begin
                    advance_cycle();
                end
            end
            if (v_op[i] == "CLR") begin
                clear_start = 1'b1;
                advance_cycle();
                // Sweep has started so ready is already low
                check_value("ready", ready, 0);
            end else begin
                find_op(v_op[i], op);
                req.op      = op;
                req.addr    = v_addr[i];
                req.wdata   = v_wdata[i];
                req_strobe  = 1'b1;
                pend_accept = (v_wait[i] != 0);
                pend_load   = (v_op[i][0] == "L");
                pend_exp    = v_exp[i];
                pend_idx    = i;
                advance_cycle();
            end
        end
        // Idle cycles catch a stray done
        repeat (2) advance_cycle();
        $display("Everything OK");
        $finish;
    end

endmodule

//--- tb/lsu_tests.txt
# op addr wdata expected_rdata wait_ready (hex except the flag; 0 = strobe now, expect no done)
# op CLR pulses clear_start; rdata is only checked for loads
LD  0000 0 0 1
LW  1ff4 0 0 1
LHU 0a46 0 0 1
LB  0123 0 0 1
SD  0100 f0e1d2c3b4a59687 0 1
LD  0100 0 f0e1d2c3b4a59687 1
LW  0100 0 ffffffffb4a59687 1
LWU 0104 0 00000000f0e1d2c3 1
LH  0102 0 ffffffffffffb4a5 1
LHU 0102 0 000000000000b4a5 1
LB  0100 0 ffffffffffffff87 1
LBU 0107 0 00000000000000f0 1
SW  0208 ffffffff7abc1234 0 1
LW  0208 0 000000007abc1234 1
SH  0212 0000000000008001 0 1
LH  0212 0 ffffffffffff8001 1
SB  021d 000000000000007f 0 1
LB  021d 0 000000000000007f 1
SB  0103 000000000000005a 0 1
LD  0100 0 f0e1d2c35aa59687 1
SW  0306 00000000deadbeef 0 1
LD  0300 0 beef00000000dead 1
LW  0306 0 ffffffffdeadbeef 1
SD  0400 0123456789abcdef 0 1
LD  0400 0 0123456789abcdef 1
CLR 0 0 0 1
LD  0100 0 0 0
LD  0100 0 0 1
LW  0306 0 0 1
LD  0400 0 0 1

//--- verilog/byte_bank.sv
/*
 One byte lane of the data memory, 1024 deep, no reset on contents.
 Read-before-write, dout updates only while en is high.
*/
`timescale 1ns/1ps

module byte_bank (
    input  logic                         clk,
    input  logic                         en,
    input  logic                         we,
    input  logic [lsu_pkg::ROW_BITS-1:0] row,
    input  logic [7:0]                   din,
    output logic [7:0]                   dout
);

    logic [7:0] mem [0:lsu_pkg::ROWS-1];

    // Single port, one cycle read latency
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[row] <= din;
            end
            // Old contents come out on a write cycle
            dout <= mem[row];
        end
    end

endmodule

//--- verilog/clear_counter.sv
/*
 Row counter for the zeroing sweep.
 Returns to row 0 after the last row so each sweep starts clean.
*/
`timescale 1ns/1ps

module clear_counter (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         en,
    output logic [lsu_pkg::ROW_BITS-1:0] row,
    output logic                         last
);

    // High while the final row is addressed
    assign last = (row == lsu_pkg::ROW_BITS'(lsu_pkg::ROWS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            row <= '0;
        end else if (en) begin
            if (last) begin
                // End of sweep
                row <= '0;
            end else begin
                row <= row + 1'b1;
            end
        end
    end

endmodule

//--- verilog/data_mem_unit.sv
/*
 Eight interleaved byte banks, all addressed with the same row.
 Bytes past the row end wrap to the start of that row.
 rdata is valid one cycle after an enabled load.
*/
`timescale 1ns/1ps

module data_mem_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       en,
    input  lsu_pkg::mem_req_t          req,
    output logic [lsu_pkg::XLEN-1:0]   rdata
);

    logic [lsu_pkg::ROW_BITS-1:0] row;
    logic [2:0]                   offset;
    logic [lsu_pkg::XLEN-1:0]     lane_data;
    logic [7:0]                   lane_we;
    logic [lsu_pkg::XLEN-1:0]     bank_data;

    // Load side context, lines up with the bank read latency
    logic [2:0]                   rd_offset;
    lsu_pkg::mem_op_e             rd_op;

    // Row from upper used bits, lane from the low three
    assign row    = req.addr[lsu_pkg::ADDR_BITS-1:3];
    assign offset = req.addr[2:0];

    store_align i_store_align (
        .op        (req.op),
        .offset    (offset),
        .wdata     (req.wdata),
        .lane_data (lane_data),
        .lane_we   (lane_we)
    );

    for (genvar i = 0; i < lsu_pkg::NUM_BANKS; i++) begin : g_bank
        byte_bank i_byte_bank (
            .clk  (clk),
            .en   (en),
            .we   (lane_we[i]),
            .row  (row),
            .din  (lane_data[i*8 +: 8]),
            .dout (bank_data[i*8 +: 8])
        );
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_offset <= '0;
            rd_op     <= lsu_pkg::LD;
        end else if (en) begin
            rd_offset <= offset;
            rd_op     <= req.op;
        end
    end

    load_align i_load_align (
        .op        (rd_op),
        .offset    (rd_offset),
        .bank_data (bank_data),
        .rdata     (rdata)
    );

endmodule

//--- verilog/load_align.sv
/*
 Load path realignment, purely combinational.
 Expects bank bytes and op/offset from the same access.
*/
`timescale 1ns/1ps

module load_align (
    input  lsu_pkg::mem_op_e           op,
    input  logic [2:0]                 offset,
    input  logic [lsu_pkg::XLEN-1:0]   bank_data,
    output logic [lsu_pkg::XLEN-1:0]   rdata
);

    logic [2*lsu_pkg::XLEN-1:0] dbl;
    logic [lsu_pkg::XLEN-1:0]   raw;
    logic                       sgn;

    // Rotate right by offset bytes so the addressed byte lands at byte 0
    assign dbl = {bank_data, bank_data} >> {offset, 3'b000};
    assign raw = dbl[lsu_pkg::XLEN-1:0];

    assign sgn = lsu_pkg::op_signed(op);

    // Trim to access width then extend
    always_comb begin
        case (lsu_pkg::op_width(op))
            lsu_pkg::W_BYTE: begin
                rdata = {{56{sgn & raw[7]}}, raw[7:0]};
            end
            lsu_pkg::W_HALF: begin
                rdata = {{48{sgn & raw[15]}}, raw[15:0]};
            end
            lsu_pkg::W_WORD: begin
                rdata = {{32{sgn & raw[31]}}, raw[31:0]};
            end
            default: begin
                // LD needs no extension
                rdata = raw;
            end
        endcase
    end

endmodule

//--- verilog/lsu_ctrl.sv
/*
 CLEAR/SERVE controller. CLEAR writes zeros to one row per cycle.
 Strobes while ready is low are dropped without a done.
 done follows every accepted strobe by exactly one cycle.
*/
`timescale 1ns/1ps

module lsu_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req_strobe,
    input  lsu_pkg::mem_req_t            req,
    input  logic                         clear_start,
    input  logic [lsu_pkg::ROW_BITS-1:0] row,
    input  logic                         last,
    output logic                         count_en,
    output logic                         mem_en,
    output lsu_pkg::mem_req_t            mem_req,
    output logic                         ready,
    output logic                         done
);

    lsu_pkg::lsu_state_e state;
    lsu_pkg::lsu_state_e state_nxt;
    lsu_pkg::mem_req_t   clear_req;
    logic                accept;

    assign ready  = (state == lsu_pkg::SERVE);
    assign accept = req_strobe & ready;

    // Sweep runs one row per cycle for the whole of CLEAR
    assign count_en = (state == lsu_pkg::CLEAR);

    // SD of zero to the counter's row
    always_comb begin
        clear_req       = '0;
        clear_req.op    = lsu_pkg::SD;
        clear_req.addr[lsu_pkg::ADDR_BITS-1:3] = row;
    end

    // Sweep writes override the CPU side
    assign mem_en  = count_en | accept;
    assign mem_req = count_en ? clear_req : req;

    always_comb begin
        state_nxt = state;
        case (state)
            lsu_pkg::CLEAR: begin
                // Last row goes out this cycle
                if (last) begin
                    state_nxt = lsu_pkg::SERVE;
                end
            end
            lsu_pkg::SERVE: begin
                if (clear_start) begin
                    state_nxt = lsu_pkg::CLEAR;
                end
            end
            default: state_nxt = lsu_pkg::CLEAR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lsu_pkg::CLEAR;
            done  <= 1'b0;
        end else begin
            state <= state_nxt;
            done  <= accept;
        end
    end

endmodule

//--- verilog/lsu_pkg.sv
/*
 Shared sizes and types for the byte-banked data memory.
 Only address bits ADDR_BITS-1..0 reach the banks; upper bits are ignored.
 Misaligned accesses wrap inside one 8-byte row, they never carry.
*/
package lsu_pkg;

    // Memory geometry, 1024 rows of 8 bytes
    localparam int XLEN      = 64;
    localparam int NUM_BANKS = 8;
    localparam int ROW_BITS  = 10;
    localparam int ROWS      = 1 << ROW_BITS;
    localparam int ADDR_BITS = ROW_BITS + 3;

    // Width codes, same encoding as funct3[1:0]
    localparam logic [1:0] W_BYTE = 2'd0;
    localparam logic [1:0] W_HALF = 2'd1;
    localparam logic [1:0] W_WORD = 2'd2;
    localparam logic [1:0] W_DBL  = 2'd3;

    typedef enum logic [3:0] {
        LB, LH, LW, LD, LBU, LHU, LWU,
        SB, SH, SW, SD
    } mem_op_e;

    // CLEAR sweeps zeros over every row, SERVE takes CPU requests
    typedef enum logic {
        CLEAR,
        SERVE
    } lsu_state_e;

    typedef struct packed {
        mem_op_e         op;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

    // Access width implied by an opcode
    function automatic logic [1:0] op_width(input mem_op_e op);
        case (op)
            LB, LBU, SB: return W_BYTE;
            LH, LHU, SH: return W_HALF;
            LW, LWU, SW: return W_WORD;
            default:     return W_DBL;
        endcase
    endfunction

    // Signed loads only
    function automatic logic op_signed(input mem_op_e op);
        return (op == LB) || (op == LH) || (op == LW);
    endfunction

    function automatic logic op_is_store(input mem_op_e op);
        return (op == SB) || (op == SH) || (op == SW) || (op == SD);
    endfunction

endpackage

//--- verilog/lsu_top.sv
/*
 Data memory top level. Zeroes all 1024 rows after reset and on clear_start.
 req_strobe counts only while ready is high, done comes one cycle later.
*/
`timescale 1ns/1ps

module lsu_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_strobe,
    input  lsu_pkg::mem_req_t          req,
    input  logic                       clear_start,
    output logic                       ready,
    output logic                       done,
    output logic [lsu_pkg::XLEN-1:0]   rdata
);

    logic [lsu_pkg::ROW_BITS-1:0] row;
    logic                         last;
    logic                         count_en;
    logic                         mem_en;
    lsu_pkg::mem_req_t            mem_req;

    lsu_ctrl i_lsu_ctrl (
        .clk         (clk),
        .rst         (rst),
        .req_strobe  (req_strobe),
        .req         (req),
        .clear_start (clear_start),
        .row         (row),
        .last        (last),
        .count_en    (count_en),
        .mem_en      (mem_en),
        .mem_req     (mem_req),
        .ready       (ready),
        .done        (done)
    );

    clear_counter i_clear_counter (
        .clk  (clk),
        .rst  (rst),
        .en   (count_en),
        .row  (row),
        .last (last)
    );

    data_mem_unit i_data_mem_unit (
        .clk   (clk),
        .rst   (rst),
        .en    (mem_en),
        .req   (mem_req),
        .rdata (rdata)
    );

endmodule

//--- verilog/store_align.sv
/*
 Store path lane steering, purely combinational.
 Lane enables wrap modulo 8 inside the row, loads give no enables.
*/
`timescale 1ns/1ps

module store_align (
    input  lsu_pkg::mem_op_e           op,
    input  logic [2:0]                 offset,
    input  logic [lsu_pkg::XLEN-1:0]   wdata,
    output logic [lsu_pkg::XLEN-1:0]   lane_data,
    output logic [7:0]                 lane_we
);

    logic [7:0]  base_mask;
    logic [15:0] mask_rot;

    // Bank b takes source byte (b - offset) mod 8
    always_comb begin
        logic [2:0] src;
        src = '0;
        for (int b = 0; b < lsu_pkg::NUM_BANKS; b++) begin
            src = 3'(b) - offset;
            lane_data[b*8 +: 8] = wdata[src*8 +: 8];
        end
    end

    // Unrotated mask, lanes 0 upward
    always_comb begin
        case (lsu_pkg::op_width(op))
            lsu_pkg::W_BYTE: base_mask = 8'b0000_0001;
            lsu_pkg::W_HALF: base_mask = 8'b0000_0011;
            lsu_pkg::W_WORD: base_mask = 8'b0000_1111;
            default:         base_mask = 8'b1111_1111;
        endcase
    end

    // Rotate left by offset, bits falling off the top return at lane 0
    assign mask_rot = {base_mask, base_mask} << offset;

    assign lane_we = lsu_pkg::op_is_store(op) ? mask_rot[15:8] : 8'h00;

endmodule
